//--- gmii_pkg.sv
`default_nettype none

// ------------------------------------------------------------
// MAC byte stream definitions
// ------------------------------------------------------------

package gmii_pkg;

  // Width of one byte on the MAC client interface
  localparam int BYTE_W = 8;

  // One byte as it moves between the MAC and the client logic
  typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

//--- client_pkg.sv
`default_nettype none

// ------------------------------------------------------------
// Client word definitions
// ------------------------------------------------------------

package client_pkg;

  // Bytes packed into one client word
  localparam int BYTES_PER_WORD = 8;

  typedef logic [BYTES_PER_WORD*gmii_pkg::BYTE_W-1:0] word_t;

  // Byte position inside a word
  typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

  // Receive sideband, byte count runs 0 to 8
  typedef struct packed {
    logic       last_word;
    logic       good;
    logic       bad;
    logic       spare;
    logic [3:0] byte_cnt;
  } rx_status_t;

  // Transmit sideband
  typedef struct packed {
    logic       last_word;
    logic [3:0] spare;
    byte_idx_t  last_idx;
  } tx_status_t;

  // Queue sideband byte, decoded per direction
  typedef union packed {
    rx_status_t rx;
    tx_status_t tx;
  } queue_aux_u;

endpackage

`default_nettype wire

//--- queue_if.sv
`timescale 1ns/1ps
`default_nettype none

// One word queue link with a valid/ready handshake
interface queue_if;

  client_pkg::word_t      bits;
  client_pkg::queue_aux_u aux;
  logic                   val;
  logic                   rdy;

  // Side that offers words
  modport producer (
    output bits,
    output aux,
    output val,
    input  rdy
  );

  // Side that takes words
  modport consumer (
    input  bits,
    input  aux,
    input  val,
    output rdy
  );

endinterface

`default_nettype wire

//--- word_queue.sv
`timescale 1ns/1ps
`default_nettype none

// First-word-fall-through queue of words plus sideband
module word_queue #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic     ethRXclock,
  input  logic     reset_eth,
  queue_if.consumer enq,
  queue_if.producer deq
);

  localparam int DEPTH = 2**DEPTH_LOG2;

  client_pkg::word_t      mem_bits [DEPTH];
  client_pkg::queue_aux_u mem_aux  [DEPTH];

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  full;
  logic                  empty;
  logic                  do_wr;
  logic                  do_rd;

  // Count reaches DEPTH only when full, so the top bit flags it
  assign full  = count[DEPTH_LOG2];
  assign empty = (count == '0);

  assign do_wr = enq.val & ~full;
  assign do_rd = deq.rdy & ~empty;

  assign enq.rdy  = ~full;
  assign deq.val  = ~empty;
  assign deq.bits = mem_bits[rd_ptr];
  assign deq.aux  = mem_aux[rd_ptr];

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ethRXclock or posedge reset_eth)
  begin
    if (reset_eth)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge ethRXclock)
  begin
    if (do_wr)
    begin
      mem_bits[wr_ptr] <= enq.bits;
      mem_aux[wr_ptr]  <= enq.aux;
    end
  end

endmodule

`default_nettype wire

//--- rx_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

// Packs received MAC bytes into client words, byte 0 in the low byte
module rx_word_packer (
  input  logic             ethRXclock,
  input  logic             reset_eth,
  input  gmii_pkg::byte_t  rx_data,
  input  logic             rx_data_valid,
  input  logic             rx_good_frame,
  input  logic             rx_bad_frame,
  queue_if.producer        words
);

  client_pkg::byte_idx_t  cnt;
  client_pkg::word_t      asm_bits;
  client_pkg::word_t      asm_next;
  client_pkg::word_t      out_bits;
  client_pkg::queue_aux_u out_aux;
  logic                   out_val;
  logic                   frame_end;
  logic                   word_full;

  assign frame_end = rx_good_frame | rx_bad_frame;
  assign word_full = rx_data_valid & (cnt == '1);

  // Drop the incoming byte into its lane
  always_comb
  begin
    asm_next = asm_bits;
    if (rx_data_valid)
      asm_next[cnt*gmii_pkg::BYTE_W +: gmii_pkg::BYTE_W] = rx_data;
  end

  // ------------------------------------------------------------
  // Byte counter and assembly register
  // ------------------------------------------------------------
  always_ff @(posedge ethRXclock or posedge reset_eth)
  begin
    if (reset_eth)
    begin
      cnt      <= '0;
      asm_bits <= '0;
      out_val  <= 1'b0;
    end
    else
    begin
      // Single-cycle offer, the queue is never waited on
      out_val <= word_full | frame_end;
      if (frame_end)
      begin
        cnt      <= '0;
        asm_bits <= '0;
      end
      else if (rx_data_valid)
      begin
        cnt      <= cnt + 1'b1;
        asm_bits <= word_full ? '0 : asm_next;
      end
    end
  end

  // Outgoing word and status
  always_ff @(posedge ethRXclock)
  begin
    if (word_full)
    begin
      out_bits   <= asm_next;
      out_aux.rx <= '{last_word: 1'b0, good: 1'b0, bad: 1'b0, spare: 1'b0,
                      byte_cnt: 4'(client_pkg::BYTES_PER_WORD)};
    end
    else if (frame_end)
    begin
      // End word carries the pending bytes, zero of them on a word boundary
      out_bits   <= asm_bits;
      out_aux.rx <= '{last_word: 1'b1, good: rx_good_frame, bad: rx_bad_frame,
                      spare: 1'b0, byte_cnt: {1'b0, cnt}};
    end
  end

  assign words.bits = out_bits;
  assign words.aux  = out_aux;
  assign words.val  = out_val;

endmodule

`default_nettype wire

//--- tx_frame_stager.sv
`timescale 1ns/1ps
`default_nettype none

// Store and forward stage, a frame leaves only once its last word is in
module tx_frame_stager #(
  parameter int DEPTH_LOG2 = 3
) (
  input  logic      ethRXclock,
  input  logic      reset_eth,
  queue_if.consumer client,
  queue_if.producer release_q
);

  queue_if stage_in ();
  queue_if stage_out ();

  logic frame_done;
  logic last_in;

  // ------------------------------------------------------------
  // Staging queue
  // ------------------------------------------------------------
  assign stage_in.bits = client.bits;
  assign stage_in.aux  = client.aux;
  assign stage_in.val  = client.val;
  assign client.rdy    = stage_in.rdy;

  word_queue #(
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) u_stage_queue (
    .ethRXclock (ethRXclock),
    .reset_eth  (reset_eth),
    .enq        (stage_in.consumer),
    .deq        (stage_out.producer)
  );

  // Last word of a frame accepted from the client
  assign last_in = client.val & stage_in.rdy & client.aux.tx.last_word;

  always_ff @(posedge ethRXclock or posedge reset_eth)
  begin
    if (reset_eth)
      frame_done <= 1'b0;
    else if (last_in)
      frame_done <= 1'b1;
    else if (frame_done && !stage_out.val)
      frame_done <= 1'b0;
  end

  // Gate the staging output until a complete frame is held
  assign release_q.bits = stage_out.bits;
  assign release_q.aux  = stage_out.aux;
  assign release_q.val  = frame_done & stage_out.val;
  assign stage_out.rdy  = frame_done & release_q.rdy;

endmodule

`default_nettype wire

//--- tx_byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

// Splits queued words into MAC bytes, first byte of a frame waits for ack
module tx_byte_serializer (
  input  logic            ethRXclock,
  input  logic            reset_eth,
  queue_if.consumer       words,
  input  logic            tx_ack,
  output gmii_pkg::byte_t tx_data,
  output logic            tx_data_valid
);

  client_pkg::tx_status_t head_stat;
  client_pkg::byte_idx_t  idx;
  logic                   in_frame;
  logic                   advance;
  logic                   word_done;

  assign head_stat = words.aux.tx;

  // Step while in a frame, or when the MAC takes byte 0
  assign advance   = words.val & (in_frame | tx_ack);
  assign word_done = advance & (idx == head_stat.last_idx);

  // Pop the head word on its last byte
  assign words.rdy = word_done;

  // ------------------------------------------------------------
  // Byte output
  // ------------------------------------------------------------
  assign tx_data_valid = words.val;
  assign tx_data       = words.bits[idx*gmii_pkg::BYTE_W +: gmii_pkg::BYTE_W];

  // ------------------------------------------------------------
  // Frame state and byte index
  // ------------------------------------------------------------
  always_ff @(posedge ethRXclock or posedge reset_eth)
  begin
    if (reset_eth)
    begin
      in_frame <= 1'b0;
      idx      <= '0;
    end
    else if (word_done)
    begin
      idx <= '0;
      // Back to waiting for ack after the frame's last word
      in_frame <= ~head_stat.last_word;
    end
    else if (advance)
    begin
      idx      <= idx + 1'b1;
      in_frame <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- mac_client_top.sv
`timescale 1ns/1ps
`default_nettype none

// Client side of the gigabit MAC wrapper, receive and transmit paths
module mac_client_top #(
  parameter int RX_DEPTH_LOG2    = 4,
  parameter int TX_DEPTH_LOG2    = 4,
  parameter int STAGE_DEPTH_LOG2 = 3
) (
  input  logic                  ethRXclock,
  input  logic                  reset_eth,

  // Receive client side
  output client_pkg::word_t     rxq_bits,
  output logic [3:0]            rxq_byte_cnt,
  output logic                  rxq_last_word,
  output logic                  rxq_good,
  output logic                  rxq_bad,
  output logic                  rxq_val,
  input  logic                  rxq_rdy,

  // Transmit client side
  input  client_pkg::word_t     txq_bits,
  input  client_pkg::byte_idx_t txq_last_idx,
  input  logic                  txq_last_word,
  input  logic                  txq_val,
  output logic                  txq_rdy,

  // MAC side
  input  gmii_pkg::byte_t       rx_data,
  input  logic                  rx_data_valid,
  input  logic                  rx_good_frame,
  input  logic                  rx_bad_frame,
  input  logic                  tx_ack,
  output gmii_pkg::byte_t       tx_data,
  output logic                  tx_data_valid
);

  queue_if rx_link ();
  queue_if rx_out ();
  queue_if tx_in ();
  queue_if tx_link ();
  queue_if tx_out ();

  client_pkg::tx_status_t tx_stat;

  // ------------------------------------------------------------
  // Receive path
  // ------------------------------------------------------------
  rx_word_packer u_rx_packer (
    .ethRXclock    (ethRXclock),
    .reset_eth     (reset_eth),
    .rx_data       (rx_data),
    .rx_data_valid (rx_data_valid),
    .rx_good_frame (rx_good_frame),
    .rx_bad_frame  (rx_bad_frame),
    .words         (rx_link.producer)
  );

  word_queue #(.DEPTH_LOG2(RX_DEPTH_LOG2)) u_rx_queue (
    .ethRXclock (ethRXclock),
    .reset_eth  (reset_eth),
    .enq        (rx_link.consumer),
    .deq        (rx_out.producer)
  );

  assign rxq_bits      = rx_out.bits;
  assign rxq_byte_cnt  = rx_out.aux.rx.byte_cnt;
  assign rxq_last_word = rx_out.aux.rx.last_word;
  assign rxq_good      = rx_out.aux.rx.good;
  assign rxq_bad       = rx_out.aux.rx.bad;
  assign rxq_val       = rx_out.val;
  assign rx_out.rdy    = rxq_rdy;

  // ------------------------------------------------------------
  // Transmit path
  // ------------------------------------------------------------
  assign tx_stat    = '{last_word: txq_last_word, spare: 4'd0, last_idx: txq_last_idx};
  assign tx_in.bits = txq_bits;
  assign tx_in.aux  = tx_stat;
  assign tx_in.val  = txq_val;
  assign txq_rdy    = tx_in.rdy;

  tx_frame_stager #(.DEPTH_LOG2(STAGE_DEPTH_LOG2)) u_tx_stager (
    .ethRXclock (ethRXclock),
    .reset_eth  (reset_eth),
    .client     (tx_in.consumer),
    .release_q  (tx_link.producer)
  );

  word_queue #(.DEPTH_LOG2(TX_DEPTH_LOG2)) u_tx_queue (
    .ethRXclock (ethRXclock),
    .reset_eth  (reset_eth),
    .enq        (tx_link.consumer),
    .deq        (tx_out.producer)
  );

  tx_byte_serializer u_tx_serializer (
    .ethRXclock    (ethRXclock),
    .reset_eth     (reset_eth),
    .words         (tx_out.consumer),
    .tx_ack        (tx_ack),
    .tx_data       (tx_data),
    .tx_data_valid (tx_data_valid)
  );

endmodule

`default_nettype wire

//--- tb_mac_client.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_client;

  localparam int TIMEOUT_CYCLES = 500;

  // Receive word as seen by the client: bits, count, last, good, bad
  typedef logic [70:0] rx_entry_t;

  logic                  ethRXclock;
  logic                  reset_eth;
  client_pkg::word_t     rxq_bits;
  logic [3:0]            rxq_byte_cnt;
  logic                  rxq_last_word;
  logic                  rxq_good;
  logic                  rxq_bad;
  logic                  rxq_val;
  logic                  rxq_rdy;
  client_pkg::word_t     txq_bits;
  client_pkg::byte_idx_t txq_last_idx;
  logic                  txq_last_word;
  logic                  txq_val;
  logic                  txq_rdy;
  gmii_pkg::byte_t       rx_data;
  logic                  rx_data_valid;
  logic                  rx_good_frame;
  logic                  rx_bad_frame;
  logic                  tx_ack;
  gmii_pkg::byte_t       tx_data;
  logic                  tx_data_valid;

  integer seed;
  int     err_count;
  int     test_err_start;
  int     pass_count;
  int     fail_count;

  rx_entry_t         exp_rx[$];
  rx_entry_t         got_rx[$];
  gmii_pkg::byte_t   frame_q[$];
  gmii_pkg::byte_t   exp_tx[$];
  client_pkg::word_t frame_words[8];
  int                frame_idx[8];

  mac_client_top #(
    .RX_DEPTH_LOG2    (4),
    .TX_DEPTH_LOG2    (4),
    .STAGE_DEPTH_LOG2 (3)
  ) dut_i (
    .ethRXclock    (ethRXclock),
    .reset_eth     (reset_eth),
    .rxq_bits      (rxq_bits),
    .rxq_byte_cnt  (rxq_byte_cnt),
    .rxq_last_word (rxq_last_word),
    .rxq_good      (rxq_good),
    .rxq_bad       (rxq_bad),
    .rxq_val       (rxq_val),
    .rxq_rdy       (rxq_rdy),
    .txq_bits      (txq_bits),
    .txq_last_idx  (txq_last_idx),
    .txq_last_word (txq_last_word),
    .txq_val       (txq_val),
    .txq_rdy       (txq_rdy),
    .rx_data       (rx_data),
    .rx_data_valid (rx_data_valid),
    .rx_good_frame (rx_good_frame),
    .rx_bad_frame  (rx_bad_frame),
    .tx_ack        (tx_ack),
    .tx_data       (tx_data),
    .tx_data_valid (tx_data_valid)
  );

  always #20 ethRXclock = ~ethRXclock;

  // Receive monitor, a transfer completes on the edge after this sample
  always @(negedge ethRXclock)
  begin
    if (!reset_eth && rxq_val && rxq_rdy)
      got_rx.push_back({rxq_bits, rxq_byte_cnt, rxq_last_word, rxq_good, rxq_bad});
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic int rand_range(input int lo, input int hi);
    rand_range = lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic next_cycle();
    @(posedge ethRXclock);
    #2;
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_count - test_err_start;
    if (errs == 0)
    begin
      pass_count++;
      $display("%s: ok", name);
    end
    else
    begin
      fail_count++;
      $display("%s: %0d errors", name, errs);
    end
    test_err_start = err_count;
  endtask

  // ------------------------------------------------------------
  // Receive model and driver
  // ------------------------------------------------------------
  task automatic model_rx_frame(input logic good);
    client_pkg::word_t w;
    int lane;
    w = '0;
    lane = 0;
    foreach (frame_q[i])
    begin
      w[lane*8 +: 8] = frame_q[i];
      lane++;
      if (lane == 8)
      begin
        exp_rx.push_back({w, 4'd8, 3'b000});
        w = '0;
        lane = 0;
      end
    end
    // End word, count 0 when the frame filled its last word
    exp_rx.push_back({w, 4'(lane), 1'b1, good, ~good});
  endtask

  task automatic drive_rx_frame(input int len, input logic good);
    frame_q.delete();
    for (int i = 0; i < len; i++)
      frame_q.push_back(gmii_pkg::byte_t'($random(seed)));
    model_rx_frame(good);
    foreach (frame_q[i])
    begin
      rx_data_valid = 1'b0;
      repeat (rand_range(0, 2)) next_cycle();
      rx_data       = frame_q[i];
      rx_data_valid = 1'b1;
      next_cycle();
    end
    rx_data_valid = 1'b0;
    repeat (rand_range(0, 2)) next_cycle();
    rx_good_frame = good;
    rx_bad_frame  = ~good;
    next_cycle();
    rx_good_frame = 1'b0;
    rx_bad_frame  = 1'b0;
    repeat (2) next_cycle();
  endtask

  task automatic compare_rx(input string name);
    int waited;
    rx_entry_t e;
    rx_entry_t g;
    waited = 0;
    while (got_rx.size() < exp_rx.size())
    begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT_CYCLES)
        abort_run("receive words still missing after the timeout");
    end
    // Give stray words a chance to show up
    repeat (4) next_cycle();
    check_value({name, " word count"}, exp_rx.size(), got_rx.size());
    for (int i = 0; i < exp_rx.size() && i < got_rx.size(); i++)
    begin
      e = exp_rx[i];
      g = got_rx[i];
      check_value($sformatf("%s word %0d bits", name, i), e[70:7], g[70:7]);
      check_value($sformatf("%s word %0d count", name, i), e[6:3], g[6:3]);
      check_value($sformatf("%s word %0d flags", name, i), e[2:0], g[2:0]);
    end
    exp_rx.delete();
    got_rx.delete();
  endtask

  // ------------------------------------------------------------
  // Transmit model, driver and byte checker
  // ------------------------------------------------------------
  task automatic build_tx_frame(input int n);
    for (int w = 0; w < n; w++)
    begin
      frame_words[w] = {$random(seed), $random(seed)};
      frame_idx[w]   = (w == n - 1) ? rand_range(0, 7) : 7;
      for (int b = 0; b <= frame_idx[w]; b++)
        exp_tx.push_back(frame_words[w][b*8 +: 8]);
    end
  endtask

  task automatic send_tx_word(input int w, input logic last);
    int waited;
    logic accepted;
    txq_val = 1'b0;
    repeat (rand_range(0, 3)) next_cycle();
    txq_bits      = frame_words[w];
    txq_last_idx  = client_pkg::byte_idx_t'(frame_idx[w]);
    txq_last_word = last;
    txq_val       = 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(negedge ethRXclock);
      accepted = txq_rdy;
      next_cycle();
      waited++;
      if (!accepted && waited > TIMEOUT_CYCLES)
        abort_run("transmit client word was never accepted");
    end
    txq_val = 1'b0;
  endtask

  task automatic check_tx_frame(input string name);
    int waited;
    int nbytes;
    nbytes = exp_tx.size();
    waited = 0;
    @(negedge ethRXclock);
    while (!tx_data_valid)
    begin
      waited++;
      if (waited > TIMEOUT_CYCLES)
        abort_run("no transmit byte appeared before the timeout");
      @(negedge ethRXclock);
    end
    check_value({name, " byte 0"}, exp_tx[0], tx_data);
    // Byte 0 must sit still until the MAC acknowledges
    repeat (rand_range(0, 5))
    begin
      @(negedge ethRXclock);
      check_value({name, " byte 0 valid"}, 1, tx_data_valid);
      check_value({name, " byte 0 held"}, exp_tx[0], tx_data);
    end
    next_cycle();
    tx_ack = 1'b1;
    @(negedge ethRXclock);
    check_value({name, " byte 0 at ack"}, exp_tx[0], tx_data);
    next_cycle();
    tx_ack = 1'b0;
    for (int k = 1; k < nbytes; k++)
    begin
      @(negedge ethRXclock);
      check_value($sformatf("%s byte %0d valid", name, k), 1, tx_data_valid);
      check_value($sformatf("%s byte %0d", name, k), exp_tx[k], tx_data);
    end
    next_cycle();
    @(negedge ethRXclock);
    check_value({name, " idle after frame"}, 0, tx_data_valid);
    next_cycle();
    exp_tx.delete();
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial
  begin
    int len;
    int n;
    seed           = 38;
    err_count      = 0;
    test_err_start = 0;
    pass_count     = 0;
    fail_count     = 0;
    ethRXclock     = 1'b0;
    reset_eth      = 1'b1;
    rxq_rdy        = 1'b1;
    txq_bits       = '0;
    txq_last_idx   = '0;
    txq_last_word  = 1'b0;
    txq_val        = 1'b0;
    rx_data        = '0;
    rx_data_valid  = 1'b0;
    rx_good_frame  = 1'b0;
    rx_bad_frame   = 1'b0;
    tx_ack         = 1'b0;
    repeat (5) @(posedge ethRXclock);
    #2;
    reset_eth = 1'b0;

    @(negedge ethRXclock);
    check_value("reset rxq_val", 0, rxq_val);
    check_value("reset tx_data_valid", 0, tx_data_valid);
    check_value("reset txq_rdy", 1, txq_rdy);
    next_cycle();
    finish_test("reset");

    // Every fifth frame lands on a word boundary
    for (int f = 0; f < 20; f++)
    begin
      len = (f % 5 == 0) ? 8 * rand_range(1, 5) : rand_range(1, 40);
      drive_rx_frame(len, rand_range(0, 1));
    end
    compare_rx("rx_packing");
    finish_test("rx_packing");

    rxq_rdy = 1'b0;
    drive_rx_frame(rand_range(1, 112), rand_range(0, 1));
    n = 0;
    while (got_rx.size() < exp_rx.size())
    begin
      rxq_rdy = rand_range(0, 1);
      next_cycle();
      n++;
      if (n > TIMEOUT_CYCLES)
        abort_run("receive queue did not drain before the timeout");
    end
    rxq_rdy = 1'b1;
    compare_rx("rx_backpressure");
    finish_test("rx_backpressure");

    for (int f = 0; f < 10; f++)
    begin
      n = rand_range(1, 8);
      build_tx_frame(n);
      for (int w = 0; w < n; w++)
        send_tx_word(w, w == n - 1);
      check_tx_frame($sformatf("tx frame %0d", f));
    end
    finish_test("tx_bytes");

    for (int f = 0; f < 3; f++)
    begin
      n = rand_range(2, 8);
      build_tx_frame(n);
      for (int w = 0; w < n - 1; w++)
        send_tx_word(w, 1'b0);
      repeat (20)
      begin
        @(negedge ethRXclock);
        check_value("store and forward hold", 0, tx_data_valid);
        next_cycle();
      end
      send_tx_word(n - 1, 1'b1);
      check_tx_frame($sformatf("stored frame %0d", f));
    end
    finish_test("store_forward");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
gmii_pkg.sv
client_pkg.sv
queue_if.sv
word_queue.sv
rx_word_packer.sv
tx_frame_stager.sv
tx_byte_serializer.sv
mac_client_top.sv
tb_mac_client.sv

//--- Bender.yml
package:
  name: mac_client

sources:
  - gmii_pkg.sv
  - client_pkg.sv
  - queue_if.sv
  - word_queue.sv
  - rx_word_packer.sv
  - tx_frame_stager.sv
  - tx_byte_serializer.sv
  - mac_client_top.sv
  - target: simulation
    files:
      - tb_mac_client.sv
